// ==== source/rtc_bus_pkg.sv ====
package rtc_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed values
    ////////////////////////////////////////////////////////////////////////////

    // Bus and field width
    localparam int unsigned DATA_W = 8;

    // External slot counter and write-phase counter width
    localparam int unsigned SLOT_W = 5;

    // Port address of the command register
    localparam logic [DATA_W-1:0] CMD_PORT_DEFAULT = 8'd16;

    // Byte placed on the bus in transfer slots
    localparam logic [DATA_W-1:0] TRANSFER_CODE = 8'hF0;

    // Sequence lengths in slot ticks
    localparam int unsigned READ_STEPS  = 7;
    localparam int unsigned WRITE_STEPS = 14;

    // Bus may be handed to the clock chip above this slot count
    localparam logic [SLOT_W-1:0] RELEASE_AFTER = 5'd11;

    // Read strobe window, both bounds exclusive
    localparam logic [SLOT_W-1:0] STROBE_LO = 5'd23;
    localparam logic [SLOT_W-1:0] STROBE_HI = 5'd29;

    // Write phases below this value always drive the bus
    localparam logic [SLOT_W-1:0] DRIVE_PHASES = 5'd7;

    ////////////////////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////////////////////

    // Low two bits of the command byte
    typedef enum logic [1:0] {
        CMD_INIT  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_MODE  = 2'd3
    } cmd_e;

    // Source of the byte on the bus
    typedef enum logic [3:0] {
        SEL_INIT, SEL_MODE, SEL_TRANSFER,
        SEL_DAY, SEL_MONTH, SEL_YEAR,
        SEL_SEC, SEL_MIN, SEL_HOUR,
        SEL_ZERO
    } slot_e;

    // Target register for a returned byte
    typedef enum logic [2:0] {
        FLD_DAY, FLD_MONTH, FLD_YEAR,
        FLD_SEC, FLD_MIN, FLD_HOUR,
        FLD_NONE
    } field_e;

endpackage

// ==== source/rtc_slot_if.sv ====
`timescale 1ns/1ps

interface rtc_slot_if;
    import rtc_bus_pkg::*;

    // Current command, decoded once in the sequencer
    cmd_e   mode;

    // Bus source and capture target for the current step
    slot_e  slot;
    field_e capture;

    // High while the design owns the bus
    logic   drive;

    // Returned byte is valid on bus_in
    logic   strobe;

    modport sequencer (
        output mode,
        output slot,
        output capture
    );

    modport driver (
        input  mode,
        input  slot,
        output drive,
        output strobe
    );

    // Field registers read the target and the strobe
    modport capturer (
        input  capture,
        input  strobe
    );

endinterface

// ==== source/rtc_step_sequencer.sv ====
`timescale 1ns/1ps

module rtc_step_sequencer #(
    parameter logic [rtc_bus_pkg::DATA_W-1:0] CMD_PORT = rtc_bus_pkg::CMD_PORT_DEFAULT
) (
    input  logic                           reloj,
    input  logic                           resetM,
    input  logic                           cmd_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] port_id,
    input  logic [rtc_bus_pkg::DATA_W-1:0] port_data,
    input  logic                           slot_tick,
    input  logic                           frame_sync,
    input  logic                           read_enable,
    rtc_slot_if.sequencer                  bus
);
    import rtc_bus_pkg::*;

    localparam int unsigned RD_W = $clog2(READ_STEPS);
    localparam int unsigned WR_W = $clog2(WRITE_STEPS);

    // Write table layout: fields, two transfers, fields again
    localparam logic [WR_W-1:0] WR_XFER_FIRST  = 4'd6;
    localparam logic [WR_W-1:0] WR_SECOND_PASS = 4'd8;

    cmd_e            cmd_q;
    logic [RD_W-1:0] rd_step;
    logic [WR_W-1:0] wr_step;
    slot_e           slot_c;
    field_e          field_c;
    logic            cap_en;

    // Field slot for a position 0..5 inside one pass
    function automatic slot_e field_slot(input logic [2:0] idx);
        case (idx)
            3'd0:    return SEL_DAY;
            3'd1:    return SEL_MONTH;
            3'd2:    return SEL_YEAR;
            3'd3:    return SEL_SEC;
            3'd4:    return SEL_MIN;
            3'd5:    return SEL_HOUR;
            default: return SEL_ZERO;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Command register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge reloj)
    begin
        if (resetM)
            cmd_q <= CMD_INIT;
        else if (cmd_wr && port_id == CMD_PORT)
        begin
            // Anything above 3 falls back to init
            if (port_data[DATA_W-1:2] != '0)
                cmd_q <= CMD_INIT;
            else
                cmd_q <= cmd_e'(port_data[1:0]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step counters, paced by the external slot tick
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge reloj)
    begin
        if (resetM || frame_sync)
            rd_step <= '0;
        else if (slot_tick)
        begin
            if (rd_step == RD_W'(READ_STEPS - 1))
                rd_step <= '0;
            else
                rd_step <= rd_step + 1'b1;
        end
    end

    always_ff @(posedge reloj)
    begin
        if (resetM || frame_sync)
            wr_step <= '0;
        else if (slot_tick)
        begin
            if (wr_step == WR_W'(WRITE_STEPS - 1))
                wr_step <= '0;
            else
                wr_step <= wr_step + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot and capture choice
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (cmd_q)
            CMD_INIT: slot_c = SEL_INIT;
            CMD_MODE: slot_c = SEL_MODE;
            CMD_READ:
            begin
                // Step 0 is the transfer byte, then day through hour
                if (rd_step == '0)
                    slot_c = SEL_TRANSFER;
                else
                    slot_c = field_slot(3'(rd_step - 1'b1));
            end
            CMD_WRITE:
            begin
                if (wr_step < WR_XFER_FIRST)
                    slot_c = field_slot(3'(wr_step));
                else if (wr_step < WR_SECOND_PASS)
                    slot_c = SEL_TRANSFER;
                else
                    slot_c = field_slot(3'(wr_step - WR_SECOND_PASS));
            end
            default: slot_c = SEL_INIT;
        endcase
    end

    // Writes only sample the bus when the control path asks for a read-back
    assign cap_en = (cmd_q == CMD_READ) || (cmd_q == CMD_WRITE && read_enable);

    always_comb
    begin
        case (slot_c)
            SEL_DAY:   field_c = FLD_DAY;
            SEL_MONTH: field_c = FLD_MONTH;
            SEL_YEAR:  field_c = FLD_YEAR;
            SEL_SEC:   field_c = FLD_SEC;
            SEL_MIN:   field_c = FLD_MIN;
            SEL_HOUR:  field_c = FLD_HOUR;
            default:   field_c = FLD_NONE;
        endcase
        if (!cap_en)
            field_c = FLD_NONE;
    end

    assign bus.mode    = cmd_q;
    assign bus.slot    = slot_c;
    assign bus.capture = field_c;

    a_rd_step_range: assert property (
        @(posedge reloj) disable iff (resetM)
        rd_step < RD_W'(READ_STEPS)
    );

endmodule

// ==== source/rtc_bus_driver.sv ====
`timescale 1ns/1ps

module rtc_bus_driver (
    input  logic                           reloj,
    input  logic                           resetM,
    input  logic [rtc_bus_pkg::DATA_W-1:0] init_cmd,
    input  logic [rtc_bus_pkg::DATA_W-1:0] mode_cmd,
    input  logic [rtc_bus_pkg::DATA_W-1:0] day_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] month_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] year_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] sec_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] min_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] hour_wr,
    input  logic [rtc_bus_pkg::SLOT_W-1:0] slot_count,
    input  logic [rtc_bus_pkg::SLOT_W-1:0] write_phase,
    rtc_slot_if.driver                     bus,
    output logic [rtc_bus_pkg::DATA_W-1:0] bus_out
);
    import rtc_bus_pkg::*;

    logic drive_q;
    logic release_c;
    logic in_window;

    ////////////////////////////////////////////////////////////////////////////
    // Output byte
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge reloj)
    begin
        case (bus.slot)
            SEL_INIT:     bus_out <= init_cmd;
            SEL_MODE:     bus_out <= mode_cmd;
            SEL_TRANSFER: bus_out <= TRANSFER_CODE;
            SEL_DAY:      bus_out <= day_wr;
            SEL_MONTH:    bus_out <= month_wr;
            SEL_YEAR:     bus_out <= year_wr;
            SEL_SEC:      bus_out <= sec_wr;
            SEL_MIN:      bus_out <= min_wr;
            SEL_HOUR:     bus_out <= hour_wr;
            SEL_ZERO:     bus_out <= '0;
            default:      bus_out <= '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus direction
    ////////////////////////////////////////////////////////////////////////////

    // Late part of the slot belongs to the clock chip
    assign release_c = slot_count > RELEASE_AFTER;

    always_ff @(posedge reloj)
    begin
        if (resetM)
            drive_q <= 1'b1;
        else
        begin
            case (bus.mode)
                CMD_INIT, CMD_MODE:
                    drive_q <= 1'b1;
                CMD_READ:
                    drive_q <= !release_c;
                CMD_WRITE:
                begin
                    // Early write phases hold the bus for the whole slot
                    if (write_phase < DRIVE_PHASES)
                        drive_q <= 1'b1;
                    else
                        drive_q <= !release_c;
                end
                default:
                    drive_q <= 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read strobe
    ////////////////////////////////////////////////////////////////////////////

    assign in_window  = (slot_count > STROBE_LO) && (slot_count < STROBE_HI);

    assign bus.drive  = drive_q;
    assign bus.strobe = !drive_q && in_window;

    // A strobe only follows an edge that saw the slot count past release
    a_strobe_released: assert property (
        @(posedge reloj) disable iff (resetM)
        bus.strobe |-> $past(release_c)
    );

endmodule

// ==== source/rtc_field_capture.sv ====
`timescale 1ns/1ps

module rtc_field_capture (
    input  logic                           reloj,
    input  logic                           resetM,
    input  logic [rtc_bus_pkg::DATA_W-1:0] bus_in,
    rtc_slot_if.capturer                   bus,
    output logic [rtc_bus_pkg::DATA_W-1:0] day_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] month_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] year_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] sec_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] min_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] hour_rd
);
    import rtc_bus_pkg::*;

    // Each field holds its last returned byte until the next capture
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            day_rd   <= '0;
            month_rd <= '0;
            year_rd  <= '0;
            sec_rd   <= '0;
            min_rd   <= '0;
            hour_rd  <= '0;
        end
        else if (bus.strobe)
        begin
            case (bus.capture)
                FLD_DAY:   day_rd   <= bus_in;
                FLD_MONTH: month_rd <= bus_in;
                FLD_YEAR:  year_rd  <= bus_in;
                FLD_SEC:   sec_rd   <= bus_in;
                FLD_MIN:   min_rd   <= bus_in;
                FLD_HOUR:  hour_rd  <= bus_in;
                // Transfer, init and mode slots carry nothing to keep
                default:   ;
            endcase
        end
    end

    // Strobe comes from the driver, capture from the sequencer
    a_capture_known: assert property (
        @(posedge reloj) disable iff (resetM)
        bus.strobe |-> !$isunknown(bus.capture)
    );

endmodule

// ==== source/rtc_bus_top.sv ====
`timescale 1ns/1ps

module rtc_bus_top #(
    parameter logic [rtc_bus_pkg::DATA_W-1:0] CMD_PORT = rtc_bus_pkg::CMD_PORT_DEFAULT
) (
    input  logic                           reloj,
    input  logic                           resetM,

    // Processor port writes
    input  logic                           cmd_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] port_id,
    input  logic [rtc_bus_pkg::DATA_W-1:0] port_data,

    // Timing from the control path
    input  logic                           slot_tick,
    input  logic                           frame_sync,
    input  logic                           read_enable,
    input  logic [rtc_bus_pkg::SLOT_W-1:0] slot_count,
    input  logic [rtc_bus_pkg::SLOT_W-1:0] write_phase,

    // Bytes to send
    input  logic [rtc_bus_pkg::DATA_W-1:0] init_cmd,
    input  logic [rtc_bus_pkg::DATA_W-1:0] mode_cmd,
    input  logic [rtc_bus_pkg::DATA_W-1:0] day_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] month_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] year_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] sec_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] min_wr,
    input  logic [rtc_bus_pkg::DATA_W-1:0] hour_wr,

    // Clock chip bus, split into both directions
    input  logic [rtc_bus_pkg::DATA_W-1:0] bus_in,
    output logic [rtc_bus_pkg::DATA_W-1:0] bus_out,
    output logic                           bus_oe,
    output logic                           read_strobe,
    output rtc_bus_pkg::slot_e             drive_sel,

    // Returned fields
    output logic [rtc_bus_pkg::DATA_W-1:0] day_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] month_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] year_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] sec_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] min_rd,
    output logic [rtc_bus_pkg::DATA_W-1:0] hour_rd
);

    rtc_slot_if bus_if ();

    rtc_step_sequencer #(
        .CMD_PORT (CMD_PORT)
    ) u_sequencer (
        .reloj       (reloj),
        .resetM      (resetM),
        .cmd_wr      (cmd_wr),
        .port_id     (port_id),
        .port_data   (port_data),
        .slot_tick   (slot_tick),
        .frame_sync  (frame_sync),
        .read_enable (read_enable),
        .bus         (bus_if.sequencer)
    );

    rtc_bus_driver u_driver (
        .reloj       (reloj),
        .resetM      (resetM),
        .init_cmd    (init_cmd),
        .mode_cmd    (mode_cmd),
        .day_wr      (day_wr),
        .month_wr    (month_wr),
        .year_wr     (year_wr),
        .sec_wr      (sec_wr),
        .min_wr      (min_wr),
        .hour_wr     (hour_wr),
        .slot_count  (slot_count),
        .write_phase (write_phase),
        .bus         (bus_if.driver),
        .bus_out     (bus_out)
    );

    rtc_field_capture u_capture (
        .reloj    (reloj),
        .resetM   (resetM),
        .bus_in   (bus_in),
        .bus      (bus_if.capturer),
        .day_rd   (day_rd),
        .month_rd (month_rd),
        .year_rd  (year_rd),
        .sec_rd   (sec_rd),
        .min_rd   (min_rd),
        .hour_rd  (hour_rd)
    );

    // Status seen by the control path
    assign bus_oe      = bus_if.drive;
    assign read_strobe = bus_if.strobe;
    assign drive_sel   = bus_if.slot;

endmodule

// ==== testbench/tb_rtc_bus.sv ====
`timescale 1ns/1ps

module tb_rtc_bus;
    import rtc_bus_pkg::*;

    localparam logic [DATA_W-1:0] PORT = CMD_PORT_DEFAULT;

    logic              reloj;
    logic              resetM;
    logic              cmd_wr;
    logic [DATA_W-1:0] port_id;
    logic [DATA_W-1:0] port_data;
    logic              slot_tick;
    logic              frame_sync;
    logic              read_enable;
    logic [SLOT_W-1:0] slot_count;
    logic [SLOT_W-1:0] write_phase;
    logic [DATA_W-1:0] init_cmd;
    logic [DATA_W-1:0] mode_cmd;
    logic [DATA_W-1:0] wr_byte [6];
    logic [DATA_W-1:0] bus_in;
    logic [DATA_W-1:0] bus_out;
    logic              bus_oe;
    logic              read_strobe;
    slot_e             drive_sel;
    logic [DATA_W-1:0] rd_byte [6];

    // Expected field contents, day through hour
    logic [DATA_W-1:0] exp_fld [6];

    int unsigned lcg_state = 86;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_start = 0;

    rtc_bus_top #(
        .CMD_PORT (PORT)
    ) dut0 (
        .reloj       (reloj),
        .resetM      (resetM),
        .cmd_wr      (cmd_wr),
        .port_id     (port_id),
        .port_data   (port_data),
        .slot_tick   (slot_tick),
        .frame_sync  (frame_sync),
        .read_enable (read_enable),
        .slot_count  (slot_count),
        .write_phase (write_phase),
        .init_cmd    (init_cmd),
        .mode_cmd    (mode_cmd),
        .day_wr      (wr_byte[0]),
        .month_wr    (wr_byte[1]),
        .year_wr     (wr_byte[2]),
        .sec_wr      (wr_byte[3]),
        .min_wr      (wr_byte[4]),
        .hour_wr     (wr_byte[5]),
        .bus_in      (bus_in),
        .bus_out     (bus_out),
        .bus_oe      (bus_oe),
        .read_strobe (read_strobe),
        .drive_sel   (drive_sel),
        .day_rd      (rd_byte[0]),
        .month_rd    (rd_byte[1]),
        .year_rd     (rd_byte[2]),
        .sec_rd      (rd_byte[3]),
        .min_rd      (rd_byte[4]),
        .hour_rd     (rd_byte[5])
    );

    initial
    begin
        reloj = 1'b0;
        forever #5 reloj = ~reloj;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus checks that hold on every edge
    ////////////////////////////////////////////////////////////////////////////

    a_strobe_oe: assert property (
        @(posedge reloj) disable iff (resetM)
        read_strobe |-> !bus_oe
    ) else
    begin
        errors++;
        $display("read_strobe was high while the design still drove the bus");
    end

    // Transfer slot puts F0 on the bus one edge later
    a_transfer_byte: assert property (
        @(posedge reloj) disable iff (resetM)
        drive_sel == SEL_TRANSFER |=> bus_out == 8'hF0
    ) else
    begin
        errors++;
        $display("Error: bus_out got %h expected f0 after a transfer slot", bus_out);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference tables and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic slot_e field_sel(input int idx);
        case (idx)
            0:       return SEL_DAY;
            1:       return SEL_MONTH;
            2:       return SEL_YEAR;
            3:       return SEL_SEC;
            4:       return SEL_MIN;
            default: return SEL_HOUR;
        endcase
    endfunction

    function automatic slot_e read_slot(input int step);
        if (step == 0)
            return SEL_TRANSFER;
        return field_sel(step - 1);
    endfunction

    // Six fields, two transfers, six fields
    function automatic slot_e write_slot(input int step);
        if (step < 6)
            return field_sel(step);
        else if (step < 8)
            return SEL_TRANSFER;
        return field_sel(step - 8);
    endfunction

    function automatic logic [7:0] slot_byte(input slot_e sel);
        case (sel)
            SEL_INIT:     return init_cmd;
            SEL_MODE:     return mode_cmd;
            SEL_TRANSFER: return 8'hF0;
            SEL_DAY:      return wr_byte[0];
            SEL_MONTH:    return wr_byte[1];
            SEL_YEAR:     return wr_byte[2];
            SEL_SEC:      return wr_byte[3];
            SEL_MIN:      return wr_byte[4];
            SEL_HOUR:     return wr_byte[5];
            default:      return 8'h00;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fields();
        string names [6];
        names = '{"day_rd", "month_rd", "year_rd", "sec_rd", "min_rd", "hour_rd"};
        for (int i = 0; i < 6; i++)
            check_val(names[i], rd_byte[i], exp_fld[i]);
    endtask

    task automatic write_cmd(input logic [7:0] port, input logic [7:0] data);
        @(negedge reloj);
        cmd_wr    = 1'b1;
        port_id   = port;
        port_data = data;
        @(negedge reloj);
        cmd_wr    = 1'b0;
        #1;
    endtask

    task automatic tick_slot();
        @(negedge reloj);
        slot_tick = 1'b1;
        @(negedge reloj);
        slot_tick = 1'b0;
        #1;
    endtask

    task automatic sync_frame();
        @(negedge reloj);
        frame_sync = 1'b1;
        @(negedge reloj);
        frame_sync = 1'b0;
        #1;
    endtask

    task automatic wait_strobe(input logic level, input int limit);
        int n;
        n = 0;
        while (read_strobe !== level && n < limit)
        begin
            @(posedge reloj);
            #1;
            n++;
        end
        if (read_strobe !== level)
        begin
            errors++;
            $display("Timeout: read_strobe stayed away from %0d for %0d cycles", level, limit);
        end
    endtask

    task automatic wait_sel(input slot_e target, input int limit);
        int n;
        n = 0;
        while (drive_sel !== target && n < limit)
        begin
            @(posedge reloj);
            #1;
            n++;
        end
        if (drive_sel !== target)
        begin
            errors++;
            $display("Timeout: drive_sel never reached %h in %0d cycles", target, limit);
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start)
            $display("Test %0d %s: passed", tests_run, name);
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - test_err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        slot_e prev;
        resetM      = 1'b1;
        cmd_wr      = 1'b0;
        port_id     = '0;
        port_data   = '0;
        slot_tick   = 1'b0;
        frame_sync  = 1'b0;
        read_enable = 1'b0;
        slot_count  = '0;
        write_phase = '0;
        bus_in      = '0;
        init_cmd    = next_rand();
        mode_cmd    = next_rand();
        for (int i = 0; i < 6; i++)
        begin
            wr_byte[i] = next_rand();
            exp_fld[i] = 8'h00;
        end
        repeat (10) @(posedge reloj);
        @(negedge reloj);
        resetM = 1'b0;
        #1;

        begin_test();
        check_val("bus_oe", 8'(bus_oe), 8'd1);
        check_val("read_strobe", 8'(read_strobe), 8'd0);
        check_fields();
        check_val("drive_sel", 8'(drive_sel), 8'(SEL_INIT));
        check_val("bus_out", bus_out, init_cmd);
        end_test("reset state");

        begin_test();
        write_cmd(PORT + 8'd5, 8'd3);
        check_val("drive_sel", 8'(drive_sel), 8'(SEL_INIT));
        write_cmd(PORT, 8'd3);
        check_val("drive_sel", 8'(drive_sel), 8'(SEL_MODE));
        check_val("bus_out", bus_out, init_cmd);
        @(posedge reloj);
        #1;
        check_val("bus_out", bus_out, mode_cmd);
        end_test("command port decode");

        begin_test();
        write_cmd(PORT, 8'd1);
        sync_frame();
        wait_sel(SEL_TRANSFER, 3);
        for (int k = 0; k < 14; k++)
        begin
            prev = read_slot(k % 7);
            check_val("drive_sel", 8'(drive_sel), 8'(prev));
            tick_slot();
            check_val("bus_out", bus_out, slot_byte(prev));
        end
        for (int k = 0; k < 3; k++)
            tick_slot();
        sync_frame();
        wait_sel(SEL_TRANSFER, 3);
        check_val("drive_sel", 8'(drive_sel), 8'(SEL_TRANSFER));
        end_test("read sequence");

        begin_test();
        for (int k = 0; k < 6; k++)
        begin
            tick_slot();
            check_val("drive_sel", 8'(drive_sel), 8'(field_sel(k)));
            @(negedge reloj);
            slot_count = 5'(24 + k % 5);
            bus_in     = exp_fld[k] ^ (next_rand() | 8'h01);
            wait_strobe(1'b1, 4);
            check_val("bus_oe", 8'(bus_oe), 8'd0);
            @(posedge reloj);
            #1;
            exp_fld[k] = bus_in;
            check_fields();
            @(negedge reloj);
            slot_count = '0;
            bus_in     = next_rand();
            wait_strobe(1'b0, 4);
        end
        end_test("read capture");

        begin_test();
        write_cmd(PORT, 8'd2);
        @(negedge reloj);
        // Released slot count, but early write phase keeps the bus
        write_phase = 5'd3;
        slot_count  = 5'd20;
        sync_frame();
        for (int k = 0; k < 14; k++)
        begin
            prev = write_slot(k);
            check_val("drive_sel", 8'(drive_sel), 8'(prev));
            check_val("bus_oe", 8'(bus_oe), 8'd1);
            tick_slot();
            check_val("bus_out", bus_out, slot_byte(prev));
        end
        check_val("drive_sel", 8'(drive_sel), 8'(write_slot(0)));
        end_test("write sequence");

        begin_test();
        sync_frame();
        check_val("drive_sel", 8'(drive_sel), 8'(SEL_DAY));
        @(negedge reloj);
        write_phase = 5'd8;
        slot_count  = 5'd25;
        read_enable = 1'b0;
        bus_in      = exp_fld[0] ^ (next_rand() | 8'h01);
        wait_strobe(1'b1, 4);
        check_val("bus_oe", 8'(bus_oe), 8'd0);
        @(posedge reloj);
        #1;
        check_fields();
        @(negedge reloj);
        read_enable = 1'b1;
        @(posedge reloj);
        #1;
        exp_fld[0] = bus_in;
        check_fields();
        @(negedge reloj);
        read_enable = 1'b0;
        slot_count  = '0;
        write_phase = '0;
        end_test("write read-back");

        $display("Tests run %0d, failed %0d, checks %0d, error count %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== compile.f ====
source/rtc_bus_pkg.sv
source/rtc_slot_if.sv
source/rtc_step_sequencer.sv
source/rtc_bus_driver.sv
source/rtc_field_capture.sv
source/rtc_bus_top.sv
testbench/tb_rtc_bus.sv

// ==== Makefile ====
BUILD = obj_dir
LOG   = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_rtc_bus --Mdir $(BUILD) -o sim_tb

run: compile
	./$(BUILD)/sim_tb | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "Simulation ended early"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
